// File: hw/axi_lane_pack.sv
`default_nettype none
`timescale 1ns/1ps

module axi_lane_pack (
  input  logic [bus_pkg::ADDR_W-1:0]     rd_addr_i,
  input  logic [bus_pkg::DATA_W/8-1:0]   rd_strb_i,
  input  logic                           fetch_i,
  input  logic [bus_pkg::ADDR_W-1:0]     wr_addr_i,
  input  logic [bus_pkg::DATA_W-1:0]     wr_data_i,
  input  logic [bus_pkg::DATA_W/8-1:0]   wr_strb_i,
  input  logic [bus_pkg::AXI_DATA_W-1:0] m_rdata_i,
  output logic [2:0]                     m_arsize_o,
  output logic [2:0]                     m_awsize_o,
  output logic [bus_pkg::AXI_DATA_W-1:0] m_wdata_o,
  output logic [bus_pkg::AXI_STRB_W-1:0] m_wstrb_o,
  output logic [bus_pkg::DATA_W-1:0]     rd_lane_o
);
  import bus_pkg::*;

  localparam int STRB_W = DATA_W / 8;

  axi_beat_t         wbeat;
  axi_beat_t         rbeat;
  logic [DATA_W-1:0] wdata_sh;
  logic [STRB_W+2:0] strb_wide;  // top bits catch a shift past the word
  logic [STRB_W-1:0] strb_sh;

  function automatic logic [2:0] size_of(input logic [STRB_W-1:0] strb);
    logic [2:0] size;
    case (strb)
      4'h1:    size = SIZE_BYTE;
      4'h3:    size = SIZE_HALF;
      4'hf:    size = SIZE_WORD;
      default: size = SIZE_BYTE;
    endcase
    return size;
  endfunction

  assign m_arsize_o = fetch_i ? SIZE_WORD : size_of(rd_strb_i);
  assign m_awsize_o = size_of(wr_strb_i);

  // same shifted word in both lanes
  always_comb begin
    wdata_sh        = wr_data_i << {wr_addr_i[1:0], 3'b000};
    wbeat.lanes.hi  = wdata_sh;
    wbeat.lanes.lo  = wdata_sh;
  end

  assign m_wdata_o = wbeat.word;

  always_comb begin
    strb_wide = {3'b000, wr_strb_i} << wr_addr_i[1:0];
    strb_sh   = strb_wide[STRB_W-1:0];
  end

  // bit 2 picks the nibble
  assign m_wstrb_o = wr_addr_i[2] ? {strb_sh, {STRB_W{1'b0}}} : {{STRB_W{1'b0}}, strb_sh};

  // read lane is left unshifted
  assign rbeat.word = m_rdata_i;
  assign rd_lane_o  = rd_addr_i[2] ? rbeat.lanes.hi : rbeat.lanes.lo;

  // strobe legal and not pushed past the word by its offset
  always_comb begin
    if (wr_strb_i != '0) begin
      assert ((wr_strb_i == 4'h1 || wr_strb_i == 4'h3 || wr_strb_i == 4'hf) &&
              strb_wide[STRB_W+2:STRB_W] == '0)
        else $error("bad write strobe %h at offset %0d", wr_strb_i, wr_addr_i[1:0]);
    end
  end

endmodule

`default_nettype wire

// File: hw/bus_arbiter.sv
`default_nettype none
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                         clk,
  input  logic                         rst,
  // fetch
  input  logic [bus_pkg::ADDR_W-1:0]   ifu_araddr_i,
  input  logic                         ifu_arvalid_i,
  output logic                         ifu_rvalid_o,
  // load
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_araddr_i,
  input  logic [bus_pkg::DATA_W/8-1:0] lsu_rstrb_i,
  input  logic                         lsu_arvalid_i,
  output logic                         lsu_rvalid_o,
  // store
  input  logic [bus_pkg::ADDR_W-1:0]   lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0]   lsu_wdata_i,
  input  logic [bus_pkg::DATA_W/8-1:0] lsu_wstrb_i,
  input  logic                         lsu_wvalid_i,
  output logic                         lsu_wready_o,
  // to lane packer
  output logic [bus_pkg::ADDR_W-1:0]   rd_addr_o,
  output logic [bus_pkg::DATA_W/8-1:0] rd_strb_o,
  output logic                         fetch_grant_o,
  output logic [bus_pkg::ADDR_W-1:0]   wr_addr_o,
  output logic [bus_pkg::DATA_W-1:0]   wr_data_o,
  output logic [bus_pkg::DATA_W/8-1:0] wr_strb_o,
  // axi handshakes
  output logic                         m_arvalid_o,
  input  logic                         m_arready_i,
  input  logic [1:0]                   m_rresp_i,
  input  logic                         m_rvalid_i,
  output logic                         m_awvalid_o,
  input  logic                         m_awready_i,
  output logic                         m_wvalid_o,
  input  logic                         m_wready_i,
  input  logic [1:0]                   m_bresp_i,
  input  logic                         m_bvalid_i,
  // timer
  output logic                         timer_rd_o,
  output logic                         timer_hi_o,
  input  logic                         timer_rvalid_i
);
  import bus_pkg::*;

  bus_state_t state_q;
  bus_state_t state_d;
  logic       last_fetch_q;  // fetch had the previous grant
  logic       aw_done_q;
  logic       w_done_q;
  logic       ls_req;
  logic       timer_hit;
  logic       store_sel;
  logic       aw_done_now;
  logic       w_done_now;

  assign ls_req = lsu_arvalid_i | lsu_wvalid_i;

  // single decode of the local mtime words
  assign timer_hit = lsu_arvalid_i & ~lsu_wvalid_i &
                     ((lsu_araddr_i == TIMER_ADDR_LO) | (lsu_araddr_i == TIMER_ADDR_HI));

  assign aw_done_now = aw_done_q | m_awready_i;
  assign w_done_now  = w_done_q | m_wready_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        // waiting load/store wins right after a fetch
        if (ls_req && (last_fetch_q || !ifu_arvalid_i)) begin
          state_d = LS_ADDR;
        end else if (ifu_arvalid_i) begin
          state_d = FETCH_ADDR;
        end
      end
      FETCH_ADDR: begin
        if (m_arready_i) begin
          state_d = FETCH_DATA;
        end
      end
      FETCH_DATA: begin
        if (m_rvalid_i) begin
          state_d = IDLE;
        end
      end
      LS_ADDR: begin
        if (lsu_wvalid_i) begin
          if (aw_done_now && w_done_now) begin
            state_d = STORE_RESP;
          end
        end else if (timer_hit || m_arready_i) begin
          state_d = LOAD_DATA;
        end
      end
      LOAD_DATA: begin
        if (m_rvalid_i || timer_rvalid_i) begin
          state_d = IDLE;
        end
      end
      STORE_RESP: begin
        if (m_bvalid_i) begin
          state_d = IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q      <= IDLE;
      last_fetch_q <= 1'b0;
      aw_done_q    <= 1'b0;
      w_done_q     <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == IDLE && state_d == FETCH_ADDR) begin
        last_fetch_q <= 1'b1;
      end else if (state_q == IDLE && state_d == LS_ADDR) begin
        last_fetch_q <= 1'b0;
      end
      if (state_q == LS_ADDR && state_d == LS_ADDR && lsu_wvalid_i) begin
        aw_done_q <= aw_done_now;
        w_done_q  <= w_done_now;
      end else begin
        aw_done_q <= 1'b0;
        w_done_q  <= 1'b0;
      end
    end
  end

  assign fetch_grant_o = (state_q == FETCH_ADDR) | (state_q == FETCH_DATA);
  assign rd_addr_o     = fetch_grant_o ? ifu_araddr_i : lsu_araddr_i;
  assign rd_strb_o     = fetch_grant_o ? '0 : lsu_rstrb_i;

  // store fields only while a store holds the bus
  assign store_sel = lsu_wvalid_i & ((state_q == LS_ADDR) | (state_q == STORE_RESP));
  assign wr_addr_o = store_sel ? lsu_awaddr_i : '0;
  assign wr_data_o = store_sel ? lsu_wdata_i : '0;
  assign wr_strb_o = store_sel ? lsu_wstrb_i : '0;

  assign m_arvalid_o = (state_q == FETCH_ADDR) |
                       ((state_q == LS_ADDR) & lsu_arvalid_i & ~lsu_wvalid_i & ~timer_hit);
  assign m_awvalid_o = (state_q == LS_ADDR) & lsu_wvalid_i & ~aw_done_q;
  assign m_wvalid_o  = (state_q == LS_ADDR) & lsu_wvalid_i & ~w_done_q;

  assign timer_rd_o = (state_q == LS_ADDR) & timer_hit;
  assign timer_hi_o = (lsu_araddr_i == TIMER_ADDR_HI);

  // response strobes
  assign ifu_rvalid_o = (state_q == FETCH_DATA) & m_rvalid_i;
  assign lsu_rvalid_o = (state_q == LOAD_DATA) & (m_rvalid_i | timer_rvalid_i);
  assign lsu_wready_o = (state_q == STORE_RESP) & m_bvalid_i;

  ar_hold: assert property (@(posedge clk) disable iff (rst)
    m_arvalid_o && !m_arready_i |=> m_arvalid_o)
    else $error("arvalid dropped before arready");

  r_okay: assert property (@(posedge clk) disable iff (rst)
    m_rvalid_i |-> m_rresp_i == RESP_OKAY)
    else $error("read response not OKAY");

  b_okay: assert property (@(posedge clk) disable iff (rst)
    m_bvalid_i |-> m_bresp_i == RESP_OKAY)
    else $error("write response not OKAY");

endmodule

`default_nettype wire

// File: hw/bus_pkg.sv
`default_nettype none

package bus_pkg;

  // widths
  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int AXI_DATA_W = 64;
  localparam int AXI_STRB_W = 8;

  // mtime words answered locally
  localparam logic [ADDR_W-1:0] TIMER_ADDR_LO = 32'h0200_bff8;
  localparam logic [ADDR_W-1:0] TIMER_ADDR_HI = 32'h0200_bffc;

  // axi size encodings
  localparam logic [2:0] SIZE_BYTE = 3'd0;
  localparam logic [2:0] SIZE_HALF = 3'd1;
  localparam logic [2:0] SIZE_WORD = 3'd2;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [2:0] {
    IDLE,
    FETCH_ADDR,
    FETCH_DATA,
    LS_ADDR,
    LOAD_DATA,
    STORE_RESP
  } bus_state_t;

  // one 64-bit beat seen whole or as two 32-bit lanes
  typedef struct packed {
    logic [DATA_W-1:0] hi;
    logic [DATA_W-1:0] lo;
  } axi_lanes_t;

  typedef union packed {
    logic [AXI_DATA_W-1:0] word;
    axi_lanes_t            lanes;
  } axi_beat_t;

endpackage

`default_nettype wire

// File: hw/bus_timer.sv
`default_nettype none
`timescale 1ns/1ps

module bus_timer (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       rd_i,
  input  logic                       hi_i,   // high word of mtime
  output logic                       rvalid_o,
  output logic [bus_pkg::DATA_W-1:0] rdata_o
);
  import bus_pkg::*;

  logic [2*DATA_W-1:0] mtime;

  // free running
  always_ff @(posedge clk) begin
    if (rst) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rvalid_o <= 1'b0;
    end else begin
      rvalid_o <= rd_i;
    end
  end

  // sampled at the request cycle
  always_ff @(posedge clk) begin
    if (rd_i) begin
      rdata_o <= hi_i ? mtime[2*DATA_W-1:DATA_W] : mtime[DATA_W-1:0];
    end
  end

endmodule

`default_nettype wire

// File: hw/core_bus.sv
`default_nettype none
`timescale 1ns/1ps

module core_bus (
  input  logic                           clk,
  input  logic                           rst,
  // fetch
  input  logic [bus_pkg::ADDR_W-1:0]     ifu_araddr_i,
  input  logic                           ifu_arvalid_i,
  output logic [bus_pkg::DATA_W-1:0]     ifu_rdata_o,
  output logic                           ifu_rvalid_o,
  // load
  input  logic [bus_pkg::ADDR_W-1:0]     lsu_araddr_i,
  input  logic [bus_pkg::DATA_W/8-1:0]   lsu_rstrb_i,
  input  logic                           lsu_arvalid_i,
  output logic [bus_pkg::DATA_W-1:0]     lsu_rdata_o,
  output logic                           lsu_rvalid_o,
  // store
  input  logic [bus_pkg::ADDR_W-1:0]     lsu_awaddr_i,
  input  logic [bus_pkg::DATA_W-1:0]     lsu_wdata_i,
  input  logic [bus_pkg::DATA_W/8-1:0]   lsu_wstrb_i,
  input  logic                           lsu_wvalid_i,
  output logic                           lsu_wready_o,
  // axi master
  output logic [bus_pkg::ADDR_W-1:0]     m_araddr_o,
  output logic [2:0]                     m_arsize_o,
  output logic                           m_arvalid_o,
  input  logic                           m_arready_i,
  input  logic [bus_pkg::AXI_DATA_W-1:0] m_rdata_i,
  input  logic [1:0]                     m_rresp_i,
  input  logic                           m_rvalid_i,
  output logic [bus_pkg::ADDR_W-1:0]     m_awaddr_o,
  output logic [2:0]                     m_awsize_o,
  output logic                           m_awvalid_o,
  input  logic                           m_awready_i,
  output logic [bus_pkg::AXI_DATA_W-1:0] m_wdata_o,
  output logic [bus_pkg::AXI_STRB_W-1:0] m_wstrb_o,
  output logic                           m_wvalid_o,
  input  logic                           m_wready_i,
  input  logic [1:0]                     m_bresp_i,
  input  logic                           m_bvalid_i
);
  import bus_pkg::*;

  logic [ADDR_W-1:0]   rd_addr;
  logic [DATA_W/8-1:0] rd_strb;
  logic                fetch_grant;
  logic [DATA_W-1:0]   wr_data;
  logic [DATA_W/8-1:0] wr_strb;
  logic [DATA_W-1:0]   rd_lane;
  logic                timer_rd;
  logic                timer_hi;
  logic                timer_rvalid;
  logic [DATA_W-1:0]   timer_rdata;

  bus_arbiter u_arbiter (
    .clk(clk), .rst(rst),
    .ifu_araddr_i(ifu_araddr_i), .ifu_arvalid_i(ifu_arvalid_i), .ifu_rvalid_o(ifu_rvalid_o),
    .lsu_araddr_i(lsu_araddr_i), .lsu_rstrb_i(lsu_rstrb_i),
    .lsu_arvalid_i(lsu_arvalid_i), .lsu_rvalid_o(lsu_rvalid_o),
    .lsu_awaddr_i(lsu_awaddr_i), .lsu_wdata_i(lsu_wdata_i), .lsu_wstrb_i(lsu_wstrb_i),
    .lsu_wvalid_i(lsu_wvalid_i), .lsu_wready_o(lsu_wready_o),
    .rd_addr_o(rd_addr), .rd_strb_o(rd_strb), .fetch_grant_o(fetch_grant),
    .wr_addr_o(m_awaddr_o), .wr_data_o(wr_data), .wr_strb_o(wr_strb),
    .m_arvalid_o(m_arvalid_o), .m_arready_i(m_arready_i),
    .m_rresp_i(m_rresp_i), .m_rvalid_i(m_rvalid_i),
    .m_awvalid_o(m_awvalid_o), .m_awready_i(m_awready_i),
    .m_wvalid_o(m_wvalid_o), .m_wready_i(m_wready_i),
    .m_bresp_i(m_bresp_i), .m_bvalid_i(m_bvalid_i),
    .timer_rd_o(timer_rd), .timer_hi_o(timer_hi), .timer_rvalid_i(timer_rvalid)
  );

  axi_lane_pack u_lane_pack (
    .rd_addr_i(rd_addr), .rd_strb_i(rd_strb), .fetch_i(fetch_grant),
    .wr_addr_i(m_awaddr_o), .wr_data_i(wr_data), .wr_strb_i(wr_strb),
    .m_rdata_i(m_rdata_i),
    .m_arsize_o(m_arsize_o), .m_awsize_o(m_awsize_o),
    .m_wdata_o(m_wdata_o), .m_wstrb_o(m_wstrb_o), .rd_lane_o(rd_lane)
  );

  bus_timer u_timer (
    .clk(clk), .rst(rst),
    .rd_i(timer_rd), .hi_i(timer_hi),
    .rvalid_o(timer_rvalid), .rdata_o(timer_rdata)
  );

  assign m_araddr_o  = rd_addr;
  assign ifu_rdata_o = rd_lane;
  assign lsu_rdata_o = timer_rvalid ? timer_rdata : rd_lane;  // local mtime wins

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sim.f \
  --top-module core_bus_tb -o core_bus_sim

out=$(./obj_dir/core_bus_sim) || true
echo "$out"
echo "$out" | grep -q "ALL CHECKS PASSED"

// File: sim.f
hw/bus_pkg.sv
hw/bus_arbiter.sv
hw/axi_lane_pack.sv
hw/bus_timer.sv
hw/core_bus.sv
test/axi_mem_model.sv
test/core_bus_tb.sv

// File: test/axi_mem_model.sv
`default_nettype none
`timescale 1ns/1ps

module axi_mem_model (
  input  logic                           clk,
  input  logic                           rst,
  input  logic [bus_pkg::ADDR_W-1:0]     araddr_i,
  input  logic [2:0]                     arsize_i,
  input  logic                           arvalid_i,
  output logic                           arready_o,
  output logic [bus_pkg::AXI_DATA_W-1:0] rdata_o,
  output logic [1:0]                     rresp_o,
  output logic                           rvalid_o,
  input  logic [bus_pkg::ADDR_W-1:0]     awaddr_i,
  input  logic [2:0]                     awsize_i,
  input  logic                           awvalid_i,
  output logic                           awready_o,
  input  logic [bus_pkg::AXI_DATA_W-1:0] wdata_i,
  input  logic [bus_pkg::AXI_STRB_W-1:0] wstrb_i,
  input  logic                           wvalid_i,
  output logic                           wready_o,
  output logic [1:0]                     bresp_o,
  output logic                           bvalid_o,
  output logic                           error_o
);
  import bus_pkg::*;

  logic [AXI_DATA_W-1:0] mem [128];
  integer                seed;
  logic [1:0]            ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
  logic                  r_pend, aw_got, w_got, b_pend;
  logic [ADDR_W-1:0]     r_addr, w_addr;
  logic [2:0]            w_size;
  axi_beat_t             wbeat;
  logic [AXI_STRB_W-1:0] w_strb;

  initial begin
    seed = 32'h84d3762d;
    for (int i = 0; i < 128; i++) begin
      mem[i] = {8'h9e ^ 8'(i), 8'(i * 3), 8'h41, 8'(i * 8 + 4),
                8'h27 ^ 8'(i), 8'(i * 5), 8'hd8, 8'(i * 8)};
    end
  end

  assign rresp_o = RESP_OKAY;
  assign bresp_o = RESP_OKAY;

  always @(posedge clk) begin
    if (rst) begin
      arready_o <= 1'b0;
      rvalid_o  <= 1'b0;
      awready_o <= 1'b0;
      wready_o  <= 1'b0;
      bvalid_o  <= 1'b0;
      error_o   <= 1'b0;
      r_pend    <= 1'b0;
      aw_got    <= 1'b0;
      w_got     <= 1'b0;
      b_pend    <= 1'b0;
      ar_cnt    <= '0;
      aw_cnt    <= '0;
      w_cnt     <= '0;
    end else begin
      rvalid_o <= 1'b0;
      bvalid_o <= 1'b0;
      if (arvalid_i && (araddr_i == TIMER_ADDR_LO || araddr_i == TIMER_ADDR_HI)) begin
        $display("timer address %h reached the AXI read channel", araddr_i);
        error_o <= 1'b1;
      end
      if (awvalid_i && (awaddr_i == TIMER_ADDR_LO || awaddr_i == TIMER_ADDR_HI)) begin
        $display("timer address %h reached the AXI write channel", awaddr_i);
        error_o <= 1'b1;
      end
      // read channel
      if (arvalid_i && arready_o) begin
        arready_o <= 1'b0;
        r_addr    <= araddr_i;
        r_pend    <= 1'b1;
        r_cnt     <= 2'($random(seed));
        ar_cnt    <= 2'($random(seed));
      end else if (arvalid_i && !r_pend) begin
        if (ar_cnt == 0) arready_o <= 1'b1;
        else ar_cnt <= ar_cnt - 1'b1;
      end
      if (r_pend) begin
        if (r_cnt == 0) begin
          rvalid_o <= 1'b1;
          rdata_o  <= mem[r_addr[9:3]];
          r_pend   <= 1'b0;
        end else r_cnt <= r_cnt - 1'b1;
      end
      // write address and data with independent readys
      if (awvalid_i && awready_o) begin
        awready_o <= 1'b0;
        aw_got    <= 1'b1;
        w_addr    <= awaddr_i;
        w_size    <= awsize_i;
        aw_cnt    <= 2'($random(seed));
      end else if (awvalid_i && !aw_got) begin
        if (aw_cnt == 0) awready_o <= 1'b1;
        else aw_cnt <= aw_cnt - 1'b1;
      end
      if (wvalid_i && wready_o) begin
        wready_o   <= 1'b0;
        w_got      <= 1'b1;
        wbeat.word <= wdata_i;
        w_strb     <= wstrb_i;
        w_cnt      <= 2'($random(seed));
      end else if (wvalid_i && !w_got) begin
        if (w_cnt == 0) wready_o <= 1'b1;
        else w_cnt <= w_cnt - 1'b1;
      end
      if (aw_got && w_got && !b_pend) begin
        b_pend <= 1'b1;
        b_cnt  <= 2'($random(seed));
        if ($countones(w_strb) != (1 << w_size)) begin
          $display("awsize %0d does not fit write strobe %h", w_size, w_strb);
          error_o <= 1'b1;
        end
      end
      if (b_pend) begin
        if (b_cnt == 0) begin
          bvalid_o <= 1'b1;
          b_pend   <= 1'b0;
          aw_got   <= 1'b0;
          w_got    <= 1'b0;
          for (int k = 0; k < AXI_STRB_W; k++) begin
            if (w_strb[k]) mem[w_addr[9:3]][k*8 +: 8] <= wbeat.word[k*8 +: 8];
          end
        end else b_cnt <= b_cnt - 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: test/core_bus_tb.sv
`default_nettype none
`timescale 1ns/1ps

module core_bus_tb;
  import bus_pkg::*;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] ifu_araddr_i, ifu_rdata_o, lsu_araddr_i, lsu_rdata_o, lsu_awaddr_i, lsu_wdata_i;
  logic        ifu_arvalid_i, ifu_rvalid_o, lsu_arvalid_i, lsu_rvalid_o;
  logic [3:0]  lsu_rstrb_i, lsu_wstrb_i;
  logic        lsu_wvalid_i, lsu_wready_o;
  logic [31:0] m_araddr_o, m_awaddr_o;
  logic [2:0]  m_arsize_o, m_awsize_o;
  logic        m_arvalid_o, m_arready_i, m_rvalid_i, m_awvalid_o, m_awready_i;
  logic [63:0] m_rdata_i, m_wdata_o;
  logic [1:0]  m_rresp_i, m_bresp_i;
  logic [7:0]  m_wstrb_o;
  logic        m_wvalid_o, m_wready_i, m_bvalid_i, model_err;
  logic [63:0] shadow [128];
  int          cycles = 0;
  int          ar_count = 0;

  core_bus core_bus_i (.*);

  axi_mem_model mem_i (
    .clk(clk), .rst(rst),
    .araddr_i(m_araddr_o), .arsize_i(m_arsize_o), .arvalid_i(m_arvalid_o),
    .arready_o(m_arready_i), .rdata_o(m_rdata_i), .rresp_o(m_rresp_i), .rvalid_o(m_rvalid_i),
    .awaddr_i(m_awaddr_o), .awsize_i(m_awsize_o), .awvalid_i(m_awvalid_o),
    .awready_o(m_awready_i), .wdata_i(m_wdata_o), .wstrb_i(m_wstrb_o), .wvalid_i(m_wvalid_o),
    .wready_o(m_wready_i), .bresp_o(m_bresp_i), .bvalid_o(m_bvalid_i), .error_o(model_err)
  );

  always #10 clk = ~clk;

  // cycle count, ar handshakes, timeout and model errors
  always @(negedge clk) begin
    cycles <= cycles + 1;
    if (m_arvalid_o && m_arready_i) ar_count <= ar_count + 1;
    if (cycles >= 4000) begin
      $display("timeout, the tests did not finish within 4000 cycles");
      $display("CHECKS FAILED");
      $fatal(1);
    end
    if (model_err) begin
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got %h expected %h", name, got, exp);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  endtask

  function automatic logic [31:0] lane_of(input logic [31:0] addr);
    return addr[2] ? shadow[addr[9:3]][63:32] : shadow[addr[9:3]][31:0];
  endfunction

  function automatic logic [2:0] size_for(input logic [3:0] strb);
    return (strb == 4'h1) ? 3'd0 : (strb == 4'h3) ? 3'd1 : 3'd2;
  endfunction

  task automatic fetch_check(input logic [31:0] addr);
    logic [31:0] data;
    logic [2:0]  size;
    size = 3'd7;
    @(posedge clk);
    ifu_araddr_i  <= addr;
    ifu_arvalid_i <= 1'b1;
    do begin
      @(negedge clk);
      if (m_arvalid_o && m_arready_i) size = m_arsize_o;
    end while (!ifu_rvalid_o);
    data = ifu_rdata_o;
    @(posedge clk);
    ifu_arvalid_i <= 1'b0;
    check_eq("ifu_rdata_o", data, lane_of(addr));
    check_eq("m_arsize_o", size, 3'd2);  // fetches are whole words
  endtask

  task automatic do_load(input logic [31:0] addr, input logic [3:0] strb,
                         output logic [31:0] data, output logic [2:0] size, output int stamp);
    size = 3'd7;  // stays 7 if no AXI read is seen
    @(posedge clk);
    lsu_araddr_i  <= addr;
    lsu_rstrb_i   <= strb;
    lsu_arvalid_i <= 1'b1;
    do begin
      @(negedge clk);
      if (m_arvalid_o && m_arready_i) size = m_arsize_o;
    end while (!lsu_rvalid_o);
    data  = lsu_rdata_o;
    stamp = cycles;
    @(posedge clk);
    lsu_arvalid_i <= 1'b0;
  endtask

  task automatic load_check(input logic [31:0] addr, input logic [3:0] strb);
    logic [31:0] data;
    logic [2:0]  size;
    int          stamp;
    do_load(addr, strb, data, size, stamp);
    check_eq("lsu_rdata_o", data, lane_of(addr));
    check_eq("m_arsize_o", size, size_for(strb));
  endtask

  task automatic store_check(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
    int pos;
    @(posedge clk);
    lsu_awaddr_i <= addr;
    lsu_wdata_i  <= data;
    lsu_wstrb_i  <= strb;
    lsu_wvalid_i <= 1'b1;
    do @(negedge clk); while (!lsu_wready_o);
    @(posedge clk);
    lsu_wvalid_i <= 1'b0;
    for (int k = 0; k < 4; k++) begin
      pos = addr[2] * 4 + addr[1:0] + k;
      if (strb[k]) shadow[addr[9:3]][pos*8 +: 8] = data[k*8 +: 8];
    end
    load_check({addr[31:2], 2'b00}, 4'hf);
  endtask

  task automatic arbitration_check();
    logic        f_done;
    logic        l_done;
    logic [31:0] fdata;
    logic [31:0] ldata;
    f_done = 1'b0;
    l_done = 1'b0;
    fetch_check(32'h40);  // fetch holds the last grant
    @(posedge clk);
    ifu_araddr_i  <= 32'h48;
    ifu_arvalid_i <= 1'b1;
    lsu_araddr_i  <= 32'h64;
    lsu_rstrb_i   <= 4'hf;
    lsu_arvalid_i <= 1'b1;
    while (!(f_done && l_done)) begin
      @(negedge clk);
      if (ifu_rvalid_o) begin
        if (!l_done) begin
          $display("fetch response came before the waiting load response");
          $display("CHECKS FAILED");
          $fatal(1);
        end
        f_done = 1'b1;
        fdata  = ifu_rdata_o;
      end
      if (lsu_rvalid_o) begin
        l_done = 1'b1;
        ldata  = lsu_rdata_o;
      end
      @(posedge clk);
      if (f_done) ifu_arvalid_i <= 1'b0;
      if (l_done) lsu_arvalid_i <= 1'b0;
    end
    check_eq("ifu_rdata_o", fdata, lane_of(32'h48));
    check_eq("lsu_rdata_o", ldata, lane_of(32'h64));
  endtask

  task automatic timer_check();
    logic [31:0] hi, t1, t2;
    logic [2:0]  size;
    int          c0, c1, c2, ar_before;
    ar_before = ar_count;
    do_load(TIMER_ADDR_HI, 4'hf, hi, size, c0);
    check_eq("mtime hi", hi, 0);
    do_load(TIMER_ADDR_LO, 4'hf, t1, size, c1);
    do_load(TIMER_ADDR_LO, 4'hf, t2, size, c2);
    check_eq("mtime lo increasing", t2 > t1, 1);
    check_eq("mtime lo step", t2 - t1, c2 - c1);
    check_eq("ar handshakes", ar_count, ar_before);
  endtask

  initial begin
    rst = 1'b1;
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_rstrb_i   = '0;
    lsu_arvalid_i = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    for (int i = 0; i < 128; i++) shadow[i] = mem_i.mem[i];

    fetch_check(32'h0);
    fetch_check(32'h4);
    fetch_check(32'h1c);
    fetch_check(32'h3f4);

    store_check(32'h100, 32'hcafe_f00d, 4'hf);
    store_check(32'h10c, 32'h1357_9bdf, 4'hf);
    store_check(32'h108, 32'h0000_a1b2, 4'h3);
    store_check(32'h10a, 32'h0000_c3d4, 4'h3);
    for (int off = 0; off < 8; off++) begin
      store_check(32'h110 + off, 32'h0000_0050 + off, 4'h1);
    end

    load_check(32'h20, 4'h1);
    load_check(32'h25, 4'h1);
    load_check(32'h22, 4'h3);
    load_check(32'h2e, 4'h3);

    arbitration_check();
    timer_check();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire
